//--- all.f
+incdir+.
timer_pkg.sv
timer_ms_tick.sv
timer_cycle_compare.sv
timer_countdown.sv
timer_regs.sv
timer_top.sv
timer_tb.sv

//--- timer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_macros.svh"

module timer_tb;

	localparam int CLOCK_HZ = 8000;
	localparam int IRQ_WINDOW = 100;

	typedef enum int {OP_WRITE, OP_READ_EXACT, OP_READ_RANGE, OP_WAIT_IRQ} op_e;

	logic                     i_clock;
	logic                     i_reset;
	logic                     i_psel;
	logic                     i_penable;
	logic                     i_pwrite;
	logic [`TIMER_ADDR_W-1:0] i_paddr;
	logic [`TIMER_DATA_W-1:0] i_pwdata;
	wire  [`TIMER_DATA_W-1:0] o_prdata;
	wire                      o_pready;
	wire                      o_pslverr;
	wire                      o_interrupt;

	// stimulus table with one entry per index across these queues
	op_e                      step_op[$];
	logic [`TIMER_ADDR_W-1:0] step_addr[$];
	logic [31:0]              step_data[$];
	logic [31:0]              step_expected[$];
	bit                       step_rel[$];
	string                    step_name[$];

	int                       cycle_count = 0;
	int                       cycle_limit = 100000;
	int                       errors = 0;
	int                       checks = 0;
	int                       seed = 81768;
	int                       irq_cycles[$];
	int                       irq_expected_total = 0;
	int                       last_write_cycle = 0;
	int                       last_read_cycle = 0;
	int                       last_window_end = 0;
	int                       last_load_cycle = -1;
	int                       cmp_irq_cycle = 0;
	logic [31:0]              last_write_value = '0;
	logic [31:0]              last_load_value = '0;
	logic [31:0]              last_read = '0;
	logic [31:0]              cmp_lo_read = '0;
	logic [31:0]              ms_samples[$];
	logic [31:0]              cyc_samples[$];
	timer_pkg::timer_mode_e   sel_mode = timer_pkg::MODE_OFF;
	timer_pkg::timer_word64_t model_cmp;

	timer_top #(
		.CLOCK_HZ (CLOCK_HZ)
	) i_timer_top (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.o_interrupt (o_interrupt)
	);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	// watchdog
	initial begin
		while (cycle_count <= cycle_limit) begin
			@(posedge i_clock);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d cycles", cycle_count);
		$display("TESTS FAILED");
		$finish;
	end

	// interrupt monitor samples the registered output at the falling edge
	initial begin
		forever begin
			@(negedge i_clock);
			if (!i_reset && o_interrupt === 1'b1) begin
				irq_cycles.push_back(cycle_count);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_word(input string name, input logic [31:0] lo, input logic [31:0] hi,
			input logic [31:0] actual);
		checks++;
		if ($isunknown(actual) || actual < lo || actual > hi) begin
			errors++;
			if (lo == hi) begin
				$display("ERROR %s: expected %h, actual %h", name, lo, actual);
			end else begin
				$display("ERROR %s: expected %h..%h, actual %h", name, lo, hi, actual);
			end
		end
	endtask

	task automatic check_word64(input string name, input timer_pkg::timer_word64_t expected,
			input timer_pkg::timer_word64_t actual);
		checks++;
		if (actual.word !== expected.word) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected.word, actual.word);
		end
	endtask

	task automatic check_mode(input string name, input timer_pkg::timer_mode_e expected,
			input timer_pkg::timer_mode_e actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %s, actual %s", name, expected.name(), actual.name());
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// apb transfers enter and leave just after a falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apb_write(input logic [`TIMER_ADDR_W-1:0] addr, input logic [31:0] data);
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = 1'b1;
		i_paddr = addr;
		i_pwdata = data;
		@(negedge i_clock);
		i_penable = 1'b1;
		@(negedge i_clock);
		// the access edge has just passed
		last_write_cycle = cycle_count;
		last_write_value = data;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [`TIMER_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic err);
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = addr;
		@(negedge i_clock);
		i_penable = 1'b1;
		#1;
		data = o_prdata;
		err = o_pslverr;
		last_read_cycle = cycle_count;
		check_bit("pready in access cycle", 1'b1, o_pready);
		@(negedge i_clock);
		i_psel = 1'b0;
		i_penable = 1'b0;
	endtask

	// counts pulses since the later of the last write and the last window
	task automatic wait_irq(input string name, input logic [31:0] delay,
			input logic [31:0] count);
		int start;
		int seen;
		int first;
		int from;
		timer_pkg::timer_mode_e implied;
		start = cycle_count;
		seen = 0;
		first = 0;
		from = (last_write_cycle > last_window_end) ? last_write_cycle : last_window_end;
		while (cycle_count < start + IRQ_WINDOW) begin
			@(negedge i_clock);
		end
		#1;
		foreach (irq_cycles[k]) begin
			if (irq_cycles[k] > from) begin
				if (seen == 0) begin
					first = irq_cycles[k];
				end
				seen++;
			end
		end
		last_window_end = cycle_count;
		irq_expected_total += count;
		checks++;
		if (seen < count) begin
			errors++;
			$display("%s: interrupt missing, %0d pulse(s) seen of %0d", name, seen, count);
		end else if (seen > count) begin
			errors++;
			$display("%s: unexpected interrupt, %0d pulse(s) seen of %0d", name, seen, count);
		end
		if (seen > 0) begin
			if (delay != 0) begin
				check_word({name, " delay"}, delay, delay, first - last_write_cycle);
			end
			// a pulse exactly one loaded count after the load is a countdown pulse
			implied = timer_pkg::MODE_COMPARE;
			if (last_load_cycle >= 0 && first - last_load_cycle == last_load_value) begin
				implied = timer_pkg::MODE_COUNTDOWN;
			end
			check_mode({name, " mode"}, sel_mode, implied);
		end
	endtask

	// rel on a write adds data to the last read, on a range read the bounds
	// are taken above the last written value, and on an interrupt wait the
	// delay follows from the compare value
	task automatic add_step(input op_e op, input logic [`TIMER_ADDR_W-1:0] addr,
			input logic [31:0] data, input logic [31:0] expected, input bit rel,
			input string name);
		step_op.push_back(op);
		step_addr.push_back(addr);
		step_data.push_back(data);
		step_expected.push_back(expected);
		step_rel.push_back(rel);
		step_name.push_back(name);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [31:0] n_load;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic        err;
		logic [31:0] exp_ms;
		logic [31:0] irq_delay;
		timer_pkg::timer_word64_t got;
		i_reset = 1'b1;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		model_cmp.word = '1;
		n_load = 3 + ($unsigned($random(seed)) % 38);

		// compare halves and address decode
		add_step(OP_WRITE, `TIMER_REG_CMP_LO, 32'h1234_5678, 0, 0, "write compare low");
		add_step(OP_WRITE, `TIMER_REG_CMP_HI, 32'hA5A5_0001, 0, 0, "write compare high");
		add_step(OP_READ_EXACT, `TIMER_REG_CMP_LO, 0, 32'h1234_5678, 0, "compare low");
		add_step(OP_READ_EXACT, `TIMER_REG_CMP_HI, 0, 32'hA5A5_0001, 0, "compare high");
		add_step(OP_READ_EXACT, 5'h18, 1, 0, 0, "unmapped 0x18");
		add_step(OP_READ_EXACT, 5'h1C, 1, 0, 0, "unmapped 0x1c");
		add_step(OP_READ_EXACT, `TIMER_REG_CYC_HI, 0, 0, 0, "cycle high");
		// milliseconds against cycles
		add_step(OP_READ_RANGE, `TIMER_REG_MS, 0, '1, 0, "ms first");
		add_step(OP_READ_RANGE, `TIMER_REG_CYC_LO, 0, '1, 0, "cycles first");
		add_step(OP_WAIT_IRQ, 0, 0, 0, 0, "quiet gap one");
		add_step(OP_WAIT_IRQ, 0, 0, 0, 0, "quiet gap two");
		add_step(OP_READ_RANGE, `TIMER_REG_MS, 0, '1, 0, "ms second");
		add_step(OP_READ_RANGE, `TIMER_REG_CYC_LO, 0, '1, 0, "cycles second");
		// compare interrupt
		add_step(OP_READ_RANGE, `TIMER_REG_CYC_LO, 0, '1, 0, "cycles before compare");
		add_step(OP_WRITE, `TIMER_REG_CMP_HI, 0, 0, 0, "clear compare high");
		add_step(OP_WRITE, `TIMER_REG_CMP_LO, 60, 0, 1, "compare 60 ahead");
		add_step(OP_WAIT_IRQ, 0, 0, 1, 1, "compare interrupt");
		add_step(OP_READ_RANGE, `TIMER_REG_CYC_LO, 1, 300, 1, "cycles past compare");
		// countdown interrupt
		add_step(OP_WRITE, `TIMER_REG_COUNTDOWN, n_load, 0, 0, "random countdown load");
		add_step(OP_READ_RANGE, `TIMER_REG_COUNTDOWN, 0, n_load, 0, "countdown after load");
		add_step(OP_WAIT_IRQ, 0, n_load, 1, 0, "countdown interrupt");
		add_step(OP_READ_EXACT, `TIMER_REG_COUNTDOWN, 0, 0, 0, "countdown spent");
		add_step(OP_WAIT_IRQ, 0, 0, 0, 0, "no second countdown pulse");
		// mode switching and short loads
		add_step(OP_WRITE, `TIMER_REG_COUNTDOWN, 30, 0, 0, "countdown of 30");
		add_step(OP_WRITE, `TIMER_REG_CMP_HI, '1, 0, 0, "back to compare");
		add_step(OP_WAIT_IRQ, 0, 0, 0, 0, "compare mode after countdown");
		add_step(OP_WRITE, `TIMER_REG_COUNTDOWN, 1, 0, 0, "load of one");
		add_step(OP_WAIT_IRQ, 0, 0, 0, 0, "quiet after one");
		add_step(OP_WRITE, `TIMER_REG_COUNTDOWN, 0, 0, 0, "load of zero");
		add_step(OP_WAIT_IRQ, 0, 0, 0, 0, "quiet after zero");
		cycle_limit = step_op.size() * 200 + 1000;

		repeat (8) @(negedge i_clock);
		i_reset = 1'b0;
		@(negedge i_clock);

		foreach (step_op[i]) begin
			case (step_op[i])
				OP_WRITE: begin
					wdata = step_rel[i] ? last_read + step_data[i] : step_data[i];
					// the count meets the offset that many cycles after the read,
					// and the pulse follows one cycle later
					if (step_rel[i]) begin
						cmp_irq_cycle = last_read_cycle + step_data[i] + 1;
					end
					apb_write(step_addr[i], wdata);
					case (step_addr[i])
						`TIMER_REG_CMP_LO: begin
							model_cmp.half.lo = wdata;
							sel_mode = timer_pkg::MODE_COMPARE;
						end
						`TIMER_REG_CMP_HI: begin
							model_cmp.half.hi = wdata;
							sel_mode = timer_pkg::MODE_COMPARE;
						end
						`TIMER_REG_COUNTDOWN: begin
							sel_mode = timer_pkg::MODE_COUNTDOWN;
							last_load_cycle = last_write_cycle;
							last_load_value = wdata;
						end
						default: ;
					endcase
				end
				OP_READ_EXACT, OP_READ_RANGE: begin
					apb_read(step_addr[i], rdata, err);
					last_read = rdata;
					if (step_op[i] == OP_READ_EXACT) begin
						check_word(step_name[i], step_expected[i], step_expected[i], rdata);
						check_bit({step_name[i], " pslverr"}, step_data[i][0], err);
					end else if (step_rel[i]) begin
						check_word(step_name[i], last_write_value + step_data[i],
							last_write_value + step_expected[i], rdata);
					end else begin
						check_word(step_name[i], step_data[i], step_expected[i], rdata);
						check_bit({step_name[i], " pslverr"}, 1'b0, err);
					end
					if (step_addr[i] == `TIMER_REG_MS) begin
						ms_samples.push_back(rdata);
					end
					if (step_addr[i] == `TIMER_REG_CYC_LO &&
							ms_samples.size() > cyc_samples.size()) begin
						cyc_samples.push_back(rdata);
					end
					if (step_addr[i] == `TIMER_REG_CMP_LO) begin
						cmp_lo_read = rdata;
					end
					if (step_addr[i] == `TIMER_REG_CMP_HI) begin
						got.half.hi = rdata;
						got.half.lo = cmp_lo_read;
						check_word64("compare word", model_cmp, got);
					end
				end
				OP_WAIT_IRQ: begin
					irq_delay = step_rel[i] ? cmp_irq_cycle - last_write_cycle : step_data[i];
					wait_irq(step_name[i], irq_delay, step_expected[i]);
				end
				default: ;
			endcase
		end

		// one millisecond per CLOCK_HZ/1000 cycles
		exp_ms = (cyc_samples[1] - cyc_samples[0]) / (CLOCK_HZ / 1000);
		check_word("ms against cycles", exp_ms - 1, exp_ms + 1, ms_samples[1] - ms_samples[0]);
		check_bit("interrupt idle at end", 1'b0, o_interrupt);
		checks++;
		if (irq_cycles.size() != irq_expected_total) begin
			errors++;
			$display("interrupt count wrong: %0d pulses seen, %0d expected",
				irq_cycles.size(), irq_expected_total);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- timer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_macros.svh"

module timer_top #(
	parameter int CLOCK_HZ = `TIMER_CLOCK_HZ_DEFAULT
) (
	input  wire                      i_clock,
	input  wire                      i_reset,
	input  wire                      i_psel,
	input  wire                      i_penable,
	input  wire                      i_pwrite,
	input  wire [`TIMER_ADDR_W-1:0]  i_paddr,
	input  wire [`TIMER_DATA_W-1:0]  i_pwdata,
	output logic [`TIMER_DATA_W-1:0] o_prdata,
	output logic                     o_pready,
	output logic                     o_pslverr,
	output logic                     o_interrupt
);

	logic [`TIMER_DATA_W-1:0] ms;
	timer_pkg::timer_word64_t cycles;
	timer_pkg::timer_word64_t compare;
	logic                     match;
	logic                     cd_load;
	logic [`TIMER_DATA_W-1:0] cd_value;
	logic [`TIMER_DATA_W-1:0] cd_count;
	logic                     expire;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register block
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	timer_regs i_timer_regs (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.i_ms        (ms),
		.i_cycles    (cycles),
		.i_cd_count  (cd_count),
		.i_match     (match),
		.i_expire    (expire),
		.o_compare   (compare),
		.o_cd_load   (cd_load),
		.o_cd_value  (cd_value),
		.o_interrupt (o_interrupt)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	timer_ms_tick #(
		.CLOCK_HZ (CLOCK_HZ)
	) i_timer_ms_tick (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.o_ms    (ms)
	);

	timer_cycle_compare i_timer_cycle_compare (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_compare (compare),
		.o_cycles  (cycles),
		.o_match   (match)
	);

	timer_countdown i_timer_countdown (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_load   (cd_load),
		.i_value  (cd_value),
		.o_count  (cd_count),
		.o_expire (expire)
	);

endmodule

`default_nettype wire

//--- timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_macros.svh"

module timer_regs (
	input  wire                           i_clock,
	input  wire                           i_reset,

	// apb slave
	input  wire                           i_psel,
	input  wire                           i_penable,
	input  wire                           i_pwrite,
	input  wire [`TIMER_ADDR_W-1:0]       i_paddr,
	input  wire [`TIMER_DATA_W-1:0]       i_pwdata,
	output logic [`TIMER_DATA_W-1:0]      o_prdata,
	output logic                          o_pready,
	output logic                          o_pslverr,

	// counter side
	input  wire [`TIMER_DATA_W-1:0]       i_ms,
	input  wire timer_pkg::timer_word64_t i_cycles,
	input  wire [`TIMER_DATA_W-1:0]       i_cd_count,
	input  wire                           i_match,
	input  wire                           i_expire,
	output timer_pkg::timer_word64_t      o_compare,
	output logic                          o_cd_load,
	output logic [`TIMER_DATA_W-1:0]      o_cd_value,

	output logic                          o_interrupt
);

	logic                     access;
	logic                     wr_en;
	logic                     rd_en;
	logic                     mapped;
	logic [`TIMER_DATA_W-1:0] read_mux;
	logic                     event_hit;
	timer_pkg::timer_mode_e   mode_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// apb access decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// zero wait states, every access cycle completes
	assign access = i_psel && i_penable;
	assign wr_en = access && i_pwrite;
	assign rd_en = access && !i_pwrite;

	always_comb begin
		mapped = 1'b1;
		read_mux = '0;
		case (i_paddr)
			`TIMER_REG_MS:        read_mux = i_ms;
			`TIMER_REG_CYC_LO:    read_mux = i_cycles.half.lo;
			`TIMER_REG_CYC_HI:    read_mux = i_cycles.half.hi;
			`TIMER_REG_CMP_LO:    read_mux = o_compare.half.lo;
			`TIMER_REG_CMP_HI:    read_mux = o_compare.half.hi;
			`TIMER_REG_COUNTDOWN: read_mux = i_cd_count;
			default:              mapped = 1'b0;
		endcase
	end

	assign o_prdata = rd_en ? read_mux : '0;
	assign o_pready = access;
	assign o_pslverr = access && !mapped;

	// countdown load goes straight through on the access cycle
	assign o_cd_load = wr_en && (i_paddr == `TIMER_REG_COUNTDOWN);
	assign o_cd_value = i_pwdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare word and mode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare starts at all ones so nothing matches before software
	// programs it
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_compare.word <= '1;
			mode_q <= timer_pkg::MODE_OFF;
		end else if (wr_en) begin
			case (i_paddr)
				`TIMER_REG_CMP_LO: begin
					o_compare.half.lo <= i_pwdata;
					mode_q <= timer_pkg::MODE_COMPARE;
				end
				`TIMER_REG_CMP_HI: begin
					o_compare.half.hi <= i_pwdata;
					mode_q <= timer_pkg::MODE_COMPARE;
				end
				`TIMER_REG_COUNTDOWN: begin
					mode_q <= timer_pkg::MODE_COUNTDOWN;
				end
				// counters are read only, unmapped writes fall away
				default: ;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// interrupt
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (mode_q)
			timer_pkg::MODE_COMPARE:   event_hit = i_match;
			timer_pkg::MODE_COUNTDOWN: event_hit = i_expire;
			default:                   event_hit = 1'b0;
		endcase
	end

	// one cycle behind the event
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_interrupt <= 1'b0;
		end else begin
			o_interrupt <= event_hit;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_penable_needs_psel: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_penable |-> i_psel
	) else begin
		$error("apb penable high without psel");
	end

	// the countdown would reload on every cycle of a longer strobe
	a_load_one_cycle: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_cd_load |=> !o_cd_load
	) else begin
		$error("countdown load strobe held past one cycle");
	end

	a_quiet_when_off: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(mode_q == timer_pkg::MODE_OFF) |-> !o_interrupt
	) else begin
		$error("interrupt raised with the timer off");
	end

endmodule

`default_nettype wire

//--- timer_countdown.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_macros.svh"

module timer_countdown (
	input  wire                      i_clock,
	input  wire                      i_reset,
	input  wire                      i_load,
	input  wire [`TIMER_DATA_W-1:0]  i_value,
	output logic [`TIMER_DATA_W-1:0] o_count,
	output logic                     o_expire
);

	// set for the one cycle after a load, so a loaded 1 never counts
	// as an expiry of its own
	logic just_loaded;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_count <= '0;
			just_loaded <= 1'b0;
		end else begin
			just_loaded <= i_load;
			if (i_load) begin
				o_count <= i_value;
			end else if (o_count != '0) begin
				o_count <= o_count - 1'b1;
			end
		end
	end

	// expiry is the step down to 1, zero simply holds
	assign o_expire = (o_count == `TIMER_DATA_W'(1)) && !just_loaded;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// only the register block may raise the count
	a_no_rise_without_load: assert property (
		@(posedge i_clock) disable iff (i_reset)
		!i_load |=> o_count <= $past(o_count)
	) else begin
		$error("countdown rose without a load");
	end

endmodule

`default_nettype wire

//--- timer_cycle_compare.sv
`timescale 1ns/1ps
`default_nettype none

module timer_cycle_compare (
	input  wire                           i_clock,
	input  wire                           i_reset,
	input  wire timer_pkg::timer_word64_t i_compare,
	output timer_pkg::timer_word64_t      o_cycles,
	output logic                          o_match
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// free-running cycle counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// wraps to zero after all ones, which is centuries away at any
	// realistic clock
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_cycles.word <= '0;
		end else begin
			o_cycles.word <= o_cycles.word + 1'b1;
		end
	end

	// equality only, the register block samples it into the interrupt
	assign o_match = (o_cycles.word == i_compare.word);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// the register block reads the halves on separate transfers and
	// relies on a steady single step between them
	a_count_steps_by_one: assert property (
		@(posedge i_clock) disable iff (i_reset)
		!$past(i_reset) |-> o_cycles.word == $past(o_cycles.word) + 64'd1
	) else begin
		$error("cycle counter did not advance by one");
	end

endmodule

`default_nettype wire

//--- timer_ms_tick.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_macros.svh"

module timer_ms_tick #(
	parameter int CLOCK_HZ = `TIMER_CLOCK_HZ_DEFAULT
) (
	input  wire                      i_clock,
	input  wire                      i_reset,
	output logic [`TIMER_DATA_W-1:0] o_ms
);

	// clock cycles per millisecond
	localparam int TICKS = CLOCK_HZ / 1000;
	localparam int PRESCALE_W = $clog2(TICKS);

	// a prescaler of fewer than two states has no width
	if (CLOCK_HZ < 2000) begin : g_clock_check
		$error("timer_ms_tick: CLOCK_HZ must be at least 2000");
	end

	logic [PRESCALE_W-1:0] prescale;
	logic                  wrap;

	assign wrap = (prescale == PRESCALE_W'(TICKS - 1));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// prescaler and millisecond count
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			o_ms <= '0;
		end else begin
			if (wrap) begin
				prescale <= '0;
				o_ms <= o_ms + 1'b1;
			end else begin
				prescale <= prescale + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- timer_pkg.sv
`default_nettype none

`include "timer_macros.svh"

package timer_pkg;

	// two register-sized halves of a 64-bit timer word
	typedef struct packed {
		logic [`TIMER_DATA_W-1:0] hi;
		logic [`TIMER_DATA_W-1:0] lo;
	} timer_halves_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// 64-bit cycle and compare word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// counters and the comparator use the whole word,
	// the bus side reaches it one half at a time
	typedef union packed {
		logic [2*`TIMER_DATA_W-1:0] word;
		timer_halves_t              half;
	} timer_word64_t;

	// which event drives the interrupt line
	typedef enum logic [1:0] {
		MODE_OFF       = 2'd0,
		MODE_COMPARE   = 2'd1,
		MODE_COUNTDOWN = 2'd2
	} timer_mode_e;

endpackage

`default_nettype wire

//--- timer_macros.svh
`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TIMER_DATA_W 32
`define TIMER_ADDR_W 5

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register byte offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TIMER_REG_MS        'h00
`define TIMER_REG_CYC_LO    'h04
`define TIMER_REG_CYC_HI    'h08
`define TIMER_REG_CMP_LO    'h0C
`define TIMER_REG_CMP_HI    'h10
`define TIMER_REG_COUNTDOWN 'h14

// default core clock in Hz
`define TIMER_CLOCK_HZ_DEFAULT 125_000_000

`endif
